//--- pwm_intb_pkg.sv
package pwm_intb_pkg;

    // ==============================
    // counter sizing
    // ==============================

    // pulse-width and gap counters share one width
    localparam int PULSE_CNT_W = 8;

    // ==============================
    // front-end and decoder results
    // ==============================

    // one channel's pulse result for a single cycle
    // valid and bad are never high together
    typedef struct packed {
        logic valid;
        logic bad;
    } pulse_evt_t;

    // one channel's decoder result
    typedef struct packed {
        // level, high while the fault is asserted
        logic fault;
        // strobe in the cycle the fault rises
        logic assert_evt;
    } ch_state_t;

    // burst counter states
    typedef enum logic [2:0] {
        IDLE = 3'd0,
        GOT1 = 3'd1,
        GOT2 = 3'd2,
        GOT3 = 3'd3,
        GOT4 = 3'd4
    } decode_st_e;

endpackage

//--- axil_pkg.sv
package axil_pkg;

    // ==============================
    // bus sizing
    // ==============================

    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // register map
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 8'h00;
    localparam logic [AXIL_ADDR_W-1:0] REG_EVENT  = 8'h04;
    localparam logic [AXIL_ADDR_W-1:0] REG_ERROR  = 8'h08;
    localparam logic [AXIL_ADDR_W-1:0] REG_ENABLE = 8'h0C;

    // ==============================
    // channel structs
    // ==============================

    // master to slave
    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] awaddr;
        logic                   awvalid;
        logic [AXIL_DATA_W-1:0] wdata;
        logic [AXIL_STRB_W-1:0] wstrb;
        logic                   wvalid;
        logic                   bready;
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   arvalid;
        logic                   rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
    } axil_rsp_t;

endpackage

//--- pwm_pulse_qualify.sv
`timescale 1ns/100ps

module pwm_pulse_qualify #(
    parameter int NUM_CH    = 4,
    parameter int PULSE_MIN = 4,
    parameter int PULSE_MAX = 8
) (
    input  logic                                   i_clk,
    input  logic                                   i_rst_n,
    input  logic [NUM_CH-1:0]                      i_intb_line_n,
    output pwm_intb_pkg::pulse_evt_t [NUM_CH-1:0]  o_evt
);
    import pwm_intb_pkg::*;

    localparam logic [PULSE_CNT_W-1:0] CNT_MIN = PULSE_CNT_W'(PULSE_MIN);
    localparam logic [PULSE_CNT_W-1:0] CNT_MAX = PULSE_CNT_W'(PULSE_MAX);
    localparam logic [PULSE_CNT_W-1:0] CNT_SAT = PULSE_CNT_W'(PULSE_MAX + 1);

    logic [NUM_CH-1:0] line_meta;
    logic [NUM_CH-1:0] line_sync;

    // ==============================
    // two-flop synchronizer
    // ==============================

    // idle lines sit high
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            line_meta <= '1;
            line_sync <= '1;
        end else begin
            line_meta <= i_intb_line_n;
            line_sync <= line_meta;
        end
    end

    // ==============================
    // per-channel width measurement
    // ==============================

    for (genvar k = 0; k < NUM_CH; k++) begin : g_ch
        logic [PULSE_CNT_W-1:0] width_cnt;
        logic                   pulse_end;
        logic                   in_window;

        // a nonzero count means the line was low up to now
        assign pulse_end = line_sync[k] && (width_cnt != '0);
        assign in_window = (width_cnt >= CNT_MIN) && (width_cnt <= CNT_MAX);

        always_ff @(posedge i_clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                width_cnt <= '0;
            end else if (line_sync[k]) begin
                width_cnt <= '0;
            end else if (width_cnt != CNT_SAT) begin
                width_cnt <= width_cnt + 1'b1;
            end
        end

        // classify once at the rising edge
        always_ff @(posedge i_clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                o_evt[k] <= '0;
            end else begin
                o_evt[k].valid <= pulse_end && in_window;
                o_evt[k].bad   <= pulse_end && !in_window;
            end
        end
    end

endmodule

//--- pwm_intb_decode.sv
`timescale 1ns/100ps

module pwm_intb_decode #(
    parameter int GAP_CYC = 20
) (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  pwm_intb_pkg::pulse_evt_t i_evt,
    output pwm_intb_pkg::ch_state_t  o_state
);
    import pwm_intb_pkg::*;

    localparam logic [PULSE_CNT_W-1:0] GAP_END = PULSE_CNT_W'(GAP_CYC);

    decode_st_e             state_q;
    decode_st_e             state_d;
    logic [PULSE_CNT_W-1:0] gap_cnt;
    logic                   gap_done;
    logic                   fault_set;
    logic                   fault_clr;

    // ==============================
    // gap timer
    // ==============================

    // restarts on each accepted pulse, holds once the gap is reached
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            gap_cnt <= '0;
        end else if (i_evt.valid) begin
            gap_cnt <= '0;
        end else if (!gap_done) begin
            gap_cnt <= gap_cnt + 1'b1;
        end
    end

    assign gap_done = (gap_cnt == GAP_END);

    // ==============================
    // burst counter
    // ==============================

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_evt.valid) begin
                    state_d = GOT1;
                end
            end
            GOT1: begin
                if (i_evt.valid) begin
                    state_d = GOT2;
                end else if (gap_done) begin
                    state_d = IDLE;
                end
            end
            GOT2: begin
                if (i_evt.valid) begin
                    state_d = GOT3;
                end else if (gap_done) begin
                    state_d = IDLE;
                end
            end
            GOT3: begin
                if (i_evt.valid) begin
                    state_d = GOT4;
                end else if (gap_done) begin
                    state_d = IDLE;
                end
            end
            // release message complete
            GOT4:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // single pulse then silence asserts, four pulses release
    assign fault_set = (state_q == GOT1) && gap_done && !i_evt.valid;
    assign fault_clr = (state_q == GOT4);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_state <= '0;
        end else begin
            o_state.assert_evt <= fault_set && !o_state.fault;
            if (fault_set) begin
                o_state.fault <= 1'b1;
            end else if (fault_clr) begin
                o_state.fault <= 1'b0;
            end
        end
    end

endmodule

//--- intb_status_axil.sv
`timescale 1ns/100ps

module intb_status_axil #(
    parameter int NUM_CH = 4
) (
    input  logic                                  i_clk,
    input  logic                                  i_rst_n,
    input  pwm_intb_pkg::ch_state_t [NUM_CH-1:0]  i_state,
    input  pwm_intb_pkg::pulse_evt_t [NUM_CH-1:0] i_evt,
    input  axil_pkg::axil_req_t                   i_axil,
    output axil_pkg::axil_rsp_t                   o_axil,
    output logic                                  o_irq
);
    import axil_pkg::*;

    logic [NUM_CH-1:0]      fault_vec;
    logic [NUM_CH-1:0]      assert_vec;
    logic [NUM_CH-1:0]      bad_vec;
    logic [NUM_CH-1:0]      event_q;
    logic [NUM_CH-1:0]      error_q;
    logic [NUM_CH-1:0]      enable_q;
    logic [AXIL_DATA_W-1:0] wmask;
    logic [NUM_CH-1:0]      wbits;
    logic                   wr_fire;
    logic                   rd_fire;
    logic                   bvalid_q;
    logic                   rvalid_q;
    logic [AXIL_DATA_W-1:0] rdata_q;
    logic [AXIL_DATA_W-1:0] rd_mux;
    logic                   irq_q;

    // flatten per-channel inputs
    always_comb begin
        for (int k = 0; k < NUM_CH; k++) begin
            fault_vec[k]  = i_state[k].fault;
            assert_vec[k] = i_state[k].assert_evt;
            bad_vec[k]    = i_evt[k].bad;
        end
    end

    // ==============================
    // write path
    // ==============================

    assign wr_fire = i_axil.awvalid && i_axil.wvalid && !bvalid_q;

    always_comb begin
        for (int b = 0; b < AXIL_DATA_W; b++) begin
            wmask[b] = i_axil.wstrb[b / 8];
        end
    end

    assign wbits = NUM_CH'(i_axil.wdata & wmask);

    // sticky set wins over write-one-to-clear
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            event_q  <= '0;
            error_q  <= '0;
            enable_q <= '0;
        end else begin
            event_q <= assert_vec |
                       (event_q & ~((wr_fire && i_axil.awaddr == REG_EVENT) ? wbits : '0));
            error_q <= bad_vec |
                       (error_q & ~((wr_fire && i_axil.awaddr == REG_ERROR) ? wbits : '0));
            if (wr_fire && i_axil.awaddr == REG_ENABLE) begin
                enable_q <= (enable_q & ~NUM_CH'(wmask)) | wbits;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bvalid_q <= 1'b0;
        end else if (bvalid_q && i_axil.bready) begin
            bvalid_q <= 1'b0;
        end else if (wr_fire) begin
            bvalid_q <= 1'b1;
        end
    end

    // ==============================
    // read path
    // ==============================

    assign rd_fire = i_axil.arvalid && !rvalid_q;

    always_comb begin
        case (i_axil.araddr)
            REG_STATUS: rd_mux = AXIL_DATA_W'(fault_vec);
            REG_EVENT:  rd_mux = AXIL_DATA_W'(event_q);
            REG_ERROR:  rd_mux = AXIL_DATA_W'(error_q);
            REG_ENABLE: rd_mux = AXIL_DATA_W'(enable_q);
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rvalid_q <= 1'b0;
        end else if (rvalid_q && i_axil.rready) begin
            rvalid_q <= 1'b0;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
        end
    end

    // held while rvalid waits
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rdata_q <= '0;
        end else if (rd_fire) begin
            rdata_q <= rd_mux;
        end
    end

    always_comb begin
        o_axil         = '0;
        o_axil.awready = wr_fire;
        o_axil.wready  = wr_fire;
        o_axil.bvalid  = bvalid_q;
        o_axil.bresp   = RESP_OKAY;
        o_axil.arready = rd_fire;
        o_axil.rvalid  = rvalid_q;
        o_axil.rdata   = rdata_q;
        o_axil.rresp   = RESP_OKAY;
    end

    // enable masks both event and error
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= |((event_q | error_q) & enable_q);
        end
    end

    assign o_irq = irq_q;

endmodule

//--- lv_intb_top.sv
`timescale 1ns/100ps

module lv_intb_top #(
    parameter int NUM_CH    = 4,
    parameter int PULSE_MIN = 4,
    parameter int PULSE_MAX = 8,
    parameter int GAP_CYC   = 20
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic [NUM_CH-1:0]   i_intb_line_n,
    input  axil_pkg::axil_req_t i_axil,
    output axil_pkg::axil_rsp_t o_axil,
    output logic [NUM_CH-1:0]   o_fault_n,
    output logic                o_irq
);
    import pwm_intb_pkg::*;

    pulse_evt_t [NUM_CH-1:0] evt;
    ch_state_t  [NUM_CH-1:0] ch_state;

    // shared front end for all channels
    pwm_pulse_qualify #(
        .NUM_CH    (NUM_CH),
        .PULSE_MIN (PULSE_MIN),
        .PULSE_MAX (PULSE_MAX)
    ) pwm_pulse_qualify_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_intb_line_n (i_intb_line_n),
        .o_evt         (evt)
    );

    // ==============================
    // one decoder per channel
    // ==============================

    for (genvar k = 0; k < NUM_CH; k++) begin : g_dec
        pwm_intb_decode #(
            .GAP_CYC (GAP_CYC)
        ) pwm_intb_decode_i (
            .i_clk   (i_clk),
            .i_rst_n (i_rst_n),
            .i_evt   (evt[k]),
            .o_state (ch_state[k])
        );

        assign o_fault_n[k] = ~ch_state[k].fault;
    end

    intb_status_axil #(
        .NUM_CH (NUM_CH)
    ) intb_status_axil_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_state (ch_state),
        .i_evt   (evt),
        .i_axil  (i_axil),
        .o_axil  (o_axil),
        .o_irq   (o_irq)
    );

endmodule

//--- lv_intb_assertions.sv
`timescale 1ns/100ps

module lv_intb_assertions (
    input logic                i_clk,
    input logic                i_rst_n,
    input axil_pkg::axil_req_t i_req,
    input axil_pkg::axil_rsp_t i_rsp,
    input logic                i_irq
);

    // ==============================
    // bus handshake
    // ==============================

    bvalid_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rsp.bvalid && !i_req.bready |=> i_rsp.bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rsp.rvalid && !i_req.rready |=> i_rsp.rvalid)
        else $error("rvalid dropped before rready");

    // read data frozen while waiting
    rdata_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rsp.rvalid && !i_req.rready |=> $stable(i_rsp.rdata))
        else $error("rdata changed while rvalid waited");

    // quiet outputs in reset
    reset_quiet: assert property (@(posedge i_clk)
        !i_rst_n |-> !i_irq && !i_rsp.bvalid && !i_rsp.rvalid)
        else $error("irq or valid high during reset");

endmodule

bind intb_status_axil lv_intb_assertions lv_intb_assertions_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_req   (i_axil),
    .i_rsp   (o_axil),
    .i_irq   (o_irq)
);

//--- tb_lv_intb_top.sv
`timescale 1ns/100ps

module tb_lv_intb_top;
    import axil_pkg::*;

    localparam int NUM_CH    = 4;
    localparam int PULSE_MIN = 4;
    localparam int PULSE_MAX = 8;
    localparam int GAP_CYC   = 20;
    localparam int HIGH_CYC  = 4;
    localparam int WAIT_MAX  = 20;

    // AXI OKAY response code
    localparam logic [1:0] EXP_OKAY = 2'b00;

    // one scenario row, width 0 draws an in-window width
    typedef struct packed {
        logic [1:0]        ch;
        logic [2:0]        pulses;
        logic [7:0]        width;
        logic [NUM_CH-1:0] enable;
        logic [NUM_CH-1:0] clr_evt;
        logic [NUM_CH-1:0] clr_err;
        logic [NUM_CH-1:0] fault_n;
        logic [NUM_CH-1:0] evt;
        logic [NUM_CH-1:0] err;
        logic              irq;
    } scen_t;

    logic              clk;
    logic              rst_n;
    logic [NUM_CH-1:0] line_n;
    axil_req_t         req;
    axil_rsp_t         rsp;
    logic [NUM_CH-1:0] fault_n;
    logic              irq;
    logic [31:0]       lfsr_q;
    string             names[$];
    scen_t             rows[$];

    lv_intb_top lv_intb_top_i (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_intb_line_n (line_n),
        .i_axil        (req),
        .o_axil        (rsp),
        .o_fault_n     (fault_n),
        .o_irq         (irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==============================
    // error handling and compares
    // ==============================

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_fault(input string name, input logic [NUM_CH-1:0] exp);
        if (fault_n !== exp) begin
            stop_on_error($sformatf("mismatch %s: o_fault_n expected %h actual %h",
                                    name, exp, fault_n));
        end
    endtask

    task automatic compare_reg(input string name, input logic [AXIL_DATA_W-1:0] exp,
                               input logic [AXIL_DATA_W-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("mismatch %s: register expected %h actual %h",
                                    name, exp, act));
        end
    endtask

    task automatic compare_irq(input string name, input logic exp);
        if (irq !== exp) begin
            stop_on_error($sformatf("mismatch %s: o_irq expected %b actual %b", name, exp, irq));
        end
    endtask

    task automatic compare_resp(input string name, input logic [1:0] exp,
                                input logic [1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("mismatch %s: response expected %b actual %b",
                                    name, exp, act));
        end
    endtask

    // ==============================
    // random widths
    // ==============================

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // four bits, one step each
    task automatic draw_width(output int w);
        logic [3:0] r;
        r = '0;
        for (int i = 0; i < 4; i++) begin
            r = {r[2:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        w = PULSE_MIN + (int'(r) % (PULSE_MAX - PULSE_MIN + 1));
    endtask

    task automatic play_burst(input int ch, input int pulses, input int width_cfg);
        int w;
        for (int p = 0; p < pulses; p++) begin
            if (width_cfg == 0) begin
                draw_width(w);
            end else begin
                w = width_cfg;
            end
            @(negedge clk);
            line_n[ch] = 1'b0;
            repeat (w) @(negedge clk);
            line_n[ch] = 1'b1;
            repeat (HIGH_CYC - 1) @(negedge clk);
        end
        // silence closes the burst
        repeat (GAP_CYC + 10) @(negedge clk);
    endtask

    // ==============================
    // bus tasks
    // ==============================

    // ready is sampled at the edge that takes the transfer
    task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr,
                              input logic [AXIL_DATA_W-1:0] data);
        int t;
        @(negedge clk);
        req.awaddr  = addr;
        req.awvalid = 1'b1;
        req.wdata   = data;
        req.wstrb   = '1;
        req.wvalid  = 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!(rsp.awready && rsp.wready) && t < WAIT_MAX);
        if (!(rsp.awready && rsp.wready)) begin
            stop_on_error("write address and data were never accepted");
        end
        @(negedge clk);
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        if (!rsp.bvalid) begin
            stop_on_error("write response did not follow the accepted write");
        end
        compare_resp($sformatf("write_%h_bresp", addr), EXP_OKAY, rsp.bresp);
        req.bready = 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (rsp.bvalid && t < WAIT_MAX);
        if (rsp.bvalid) begin
            stop_on_error("write response stayed valid after bready");
        end
        req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr,
                             output logic [AXIL_DATA_W-1:0] data);
        int t;
        @(negedge clk);
        req.araddr  = addr;
        req.arvalid = 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!rsp.arready && t < WAIT_MAX);
        if (!rsp.arready) begin
            stop_on_error("read address was never accepted");
        end
        @(negedge clk);
        req.arvalid = 1'b0;
        if (!rsp.rvalid) begin
            stop_on_error("read data did not follow the accepted address");
        end
        data = rsp.rdata;
        compare_resp($sformatf("read_%h_rresp", addr), EXP_OKAY, rsp.rresp);
        req.rready = 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (rsp.rvalid && t < WAIT_MAX);
        if (rsp.rvalid) begin
            stop_on_error("read data stayed valid after rready");
        end
        req.rready = 1'b0;
    endtask

    task automatic check_reg(input string name, input logic [AXIL_ADDR_W-1:0] addr,
                             input logic [AXIL_DATA_W-1:0] exp);
        logic [AXIL_DATA_W-1:0] rd;
        axil_read(addr, rd);
        compare_reg(name, exp, rd);
    endtask

    // ==============================
    // scenario table
    // ==============================

    task automatic add_row(input string name, input int ch, input int pulses, input int width,
                           input logic [NUM_CH-1:0] enable, input logic [NUM_CH-1:0] clr_evt,
                           input logic [NUM_CH-1:0] clr_err, input logic [NUM_CH-1:0] exp_fault_n,
                           input logic [NUM_CH-1:0] exp_evt, input logic [NUM_CH-1:0] exp_err,
                           input logic exp_irq);
        scen_t r;
        r.ch      = 2'(ch);
        r.pulses  = 3'(pulses);
        r.width   = 8'(width);
        r.enable  = enable;
        r.clr_evt = clr_evt;
        r.clr_err = clr_err;
        r.fault_n = exp_fault_n;
        r.evt     = exp_evt;
        r.err     = exp_err;
        r.irq     = exp_irq;
        names.push_back(name);
        rows.push_back(r);
    endtask

    task automatic load_table();
        // name, ch, pulses, width, enable, clr_evt, clr_err, fault_n, event, error, irq
        add_row("ch0_assert",       0, 1,  0, 4'h0, 4'h0, 4'h0, 4'he, 4'h1, 4'h0, 1'b0);
        add_row("ch0_release",      0, 4,  0, 4'h0, 4'h0, 4'h0, 4'hf, 4'h1, 4'h0, 1'b0);
        add_row("ch1_burst2",       1, 2,  0, 4'h0, 4'h0, 4'h0, 4'hf, 4'h1, 4'h0, 1'b0);
        add_row("ch1_burst3",       1, 3,  0, 4'h0, 4'h0, 4'h0, 4'hf, 4'h1, 4'h0, 1'b0);
        add_row("ch2_short",        2, 1,  2, 4'h0, 4'h0, 4'h0, 4'hf, 4'h1, 4'h4, 1'b0);
        add_row("ch3_long",         3, 1, 12, 4'h0, 4'h0, 4'h0, 4'hf, 4'h1, 4'hc, 1'b0);
        add_row("clear_all",        0, 0,  0, 4'h0, 4'hf, 4'hf, 4'hf, 4'h0, 4'h0, 1'b0);
        add_row("ch1_irq",          1, 1,  0, 4'h2, 4'h0, 4'h0, 4'hd, 4'h2, 4'h0, 1'b1);
        add_row("ch1_ack",          1, 0,  0, 4'h2, 4'h2, 4'h0, 4'hd, 4'h0, 4'h0, 1'b0);
        add_row("ch2_masked",       2, 1,  0, 4'h2, 4'h0, 4'h0, 4'h9, 4'h4, 4'h0, 1'b0);
        add_row("ch3_err_irq",      3, 1,  2, 4'h8, 4'h0, 4'h0, 4'h9, 4'h4, 4'h8, 1'b1);
        add_row("ch3_err_ack",      3, 0,  0, 4'h8, 4'h0, 4'h8, 4'h9, 4'h4, 4'h0, 1'b0);
        add_row("ch0_rand_assert",  0, 1,  0, 4'ha, 4'h0, 4'h0, 4'h8, 4'h5, 4'h0, 1'b0);
        add_row("ch1_rand_release", 1, 4,  0, 4'ha, 4'h0, 4'h0, 4'ha, 4'h5, 4'h0, 1'b0);
        add_row("ch2_rand_release", 2, 4,  0, 4'ha, 4'h0, 4'h0, 4'he, 4'h5, 4'h0, 1'b0);
        add_row("ch3_rand_burst3",  3, 3,  0, 4'ha, 4'h0, 4'h0, 4'he, 4'h5, 4'h0, 1'b0);
        add_row("ch0_rand_release", 0, 4,  0, 4'ha, 4'h0, 4'h0, 4'hf, 4'h5, 4'h0, 1'b0);
    endtask

    // ==============================
    // main sequence
    // ==============================

    initial begin
        scen_t             r;
        logic [NUM_CH-1:0] status;
        rst_n   = 1'b0;
        line_n  = '1;
        req     = '0;
        lfsr_q  = 32'heb187250;
        load_table();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        compare_fault("reset", '1);
        compare_irq("reset", 1'b0);
        check_reg("reset_status", REG_STATUS, '0);
        check_reg("reset_event", REG_EVENT, '0);
        check_reg("reset_error", REG_ERROR, '0);
        check_reg("reset_enable", REG_ENABLE, '0);
        // unmapped offset
        check_reg("reset_unmapped", 8'h10, '0);

        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            axil_write(REG_ENABLE, AXIL_DATA_W'(r.enable));
            axil_write(REG_EVENT, AXIL_DATA_W'(r.clr_evt));
            axil_write(REG_ERROR, AXIL_DATA_W'(r.clr_err));
            play_burst(int'(r.ch), int'(r.pulses), int'(r.width));
            status = ~r.fault_n;
            compare_fault(names[i], r.fault_n);
            compare_irq(names[i], r.irq);
            check_reg({names[i], "_status"}, REG_STATUS, AXIL_DATA_W'(status));
            check_reg({names[i], "_event"}, REG_EVENT, AXIL_DATA_W'(r.evt));
            check_reg({names[i], "_error"}, REG_ERROR, AXIL_DATA_W'(r.err));
            check_reg({names[i], "_enable"}, REG_ENABLE, AXIL_DATA_W'(r.enable));
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- verilog.f
pwm_intb_pkg.sv
axil_pkg.sv
pwm_pulse_qualify.sv
pwm_intb_decode.sv
intb_status_axil.sv
lv_intb_top.sv
lv_intb_assertions.sv
tb_lv_intb_top.sv

//--- run.sh
#!/bin/sh
# build and run, exit status reports pass or fail
verilator --binary --assert --top-module tb_lv_intb_top -f verilog.f -o sim_tb \
    && ./obj_dir/sim_tb \
    || exit 1
